// File: hw/filter.sv
`timescale 1ns/1ns

module filter (
	input  logic clk,
	input  logic reset,
	input  logic i_pixel_valid,
	input  logic [img_filter_pkg::pixel_w-1:0] i_pixel,
	input  logic [img_filter_pkg::num_coefs*img_filter_pkg::coef_w-1:0] i_coefs,
	input  logic [img_filter_pkg::shift_w-1:0] i_shift,
	output logic o_valid,
	output logic o_frame_done,
	output logic [img_filter_pkg::pixel_w-1:0] o_data
);
	import img_filter_pkg::*;

	// Circular row pipelines, one padded row each
	logic [pixel_w-1:0] pipe [num_row_bufs][row_depth];
	logic [num_row_bufs-1:0] wr_en;

	// Index of the pipeline being written
	logic [buf_idx_w-1:0] buf_idx;
	logic [buf_idx_w-1:0] top_idx;
	logic [buf_idx_w-1:0] mid_idx;

	// Position in the padded frame
	logic [$clog2(row_depth)-1:0] col_cnt;
	logic [$clog2(img_height + 2)-1:0] rows_done;
	logic [$clog2(kernel_size)-1:0] rows_ready;
	logic row_end;
	logic last_row;

	// Window stage
	logic win_adv;
	logic win_valid;
	logic frame_end;
	logic frame_done;
	logic [kernel_size*pixel_w-1:0] taps;

	// Convolver result
	logic conv_valid;
	logic conv_done;
	logic signed [acc_w-1:0] conv_data;

	assign row_end = (col_cnt == row_depth - 1);
	// rows_done counts finished rows, so it also names the row being written
	assign last_row = (rows_done == img_height + 1);

	// Two newest complete rows, the incoming pixel is the bottom tap
	assign top_idx = buf_idx - buf_idx_w'(kernel_size - 1);
	assign mid_idx = buf_idx - buf_idx_w'(1);

	always_ff @(posedge clk) begin
		if (reset) begin
			col_cnt <= '0;
			rows_done <= '0;
			rows_ready <= '0;
			buf_idx <= '0;
			wr_en <= num_row_bufs'(1);
			win_adv <= 1'b0;
			win_valid <= 1'b0;
			frame_end <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			win_adv <= i_pixel_valid;
			// Done trails the last window by one cycle
			frame_done <= frame_end;
			frame_end <= i_pixel_valid && row_end && last_row;

			// Result only where the window is centered on an active pixel
			win_valid <= i_pixel_valid
				&& (rows_ready == kernel_size - 1)
				&& (col_cnt >= kernel_size - 1)
				&& !frame_end;

			if (i_pixel_valid) begin
				if (row_end) begin
					col_cnt <= '0;
					// Next pipeline takes the next row
					wr_en <= {wr_en[num_row_bufs-2:0], wr_en[num_row_bufs-1]};
					buf_idx <= buf_idx + 1'b1;
					if (last_row) begin
						// Back to start for the next frame
						rows_done <= '0;
						rows_ready <= '0;
					end else begin
						rows_done <= rows_done + 1'b1;
						if (rows_ready < kernel_size - 1) begin
							rows_ready <= rows_ready + 1'b1;
						end
					end
				end else begin
					col_cnt <= col_cnt + 1'b1;
				end
			end
		end
	end

	// Row pipelines move only on accepted pixels
	// Enabled one takes the input, the rest recirculate their tail
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < num_row_bufs; i++) begin
				for (int j = 0; j < row_depth; j++) begin
					pipe[i][j] <= '0;
				end
			end
		end else if (i_pixel_valid) begin
			for (int i = 0; i < num_row_bufs; i++) begin
				pipe[i][0] <= wr_en[i] ? i_pixel : pipe[i][row_depth - 1];
				for (int j = 1; j < row_depth; j++) begin
					pipe[i][j] <= pipe[i][j - 1];
				end
			end
		end
	end

	// Crossbar, tails are column-aligned with the incoming pixel
	always_ff @(posedge clk) begin
		if (i_pixel_valid) begin
			taps <= {pipe[top_idx][row_depth - 1], pipe[mid_idx][row_depth - 1], i_pixel};
		end
	end

	kernel_convolver u_convolver (
		.clk       (clk),
		.reset     (reset),
		.i_advance (win_adv),
		.i_valid   (win_valid),
		.i_done    (frame_done),
		.i_taps    (taps),
		.i_coefs   (i_coefs),
		.i_shift   (i_shift),
		.o_valid   (conv_valid),
		.o_done    (conv_done),
		.o_data    (conv_data)
	);

	// Clamp to the pixel range
	always_ff @(posedge clk) begin
		if (conv_data < 0) begin
			o_data <= '0;
		end else if (conv_data > pixel_max) begin
			o_data <= pixel_w'(pixel_max);
		end else begin
			o_data <= conv_data[pixel_w-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			o_valid <= 1'b0;
			o_frame_done <= 1'b0;
		end else begin
			o_valid <= conv_valid;
			o_frame_done <= conv_done;
		end
	end

	// Exactly one pipeline written at a time
	// The written one is also the one the crossbar counts back from
	wr_en_onehot: assert property (
		@(posedge clk) disable iff (reset)
		$onehot(wr_en) && wr_en[buf_idx]
	) else $error("row pipeline write enable not one-hot or out of step with buf_idx");

endmodule

// File: hw/img_filter_pkg.sv
package img_filter_pkg;

	// Active frame size, the zero border is not counted
	localparam int img_width = 6;
	localparam int img_height = 4;

	// Padded row length, also the depth of each row pipeline
	localparam int row_depth = img_width + 2;

	localparam int kernel_size = 3;
	localparam int num_coefs = kernel_size * kernel_size;

	// One row is written while the others are read
	localparam int num_row_bufs = kernel_size + 1;
	localparam int buf_idx_w = 2;

	// Pixels are unsigned
	localparam int pixel_w = 8;
	localparam int pixel_max = (1 << pixel_w) - 1;

	// Signed coefficients, packed with coefficient k at bits [k*coef_w +: coef_w]
	// k runs row-major from the top-left tap
	localparam int coef_w = 8;
	localparam int shift_w = 3;

	// Unsigned pixel times signed coefficient, sign bit added for the pixel
	localparam int prod_w = pixel_w + coef_w + 1;

	// Nine products summed with headroom
	localparam int acc_w = 20;

	// Config port map, 0..8 are coefficients
	localparam int cfg_addr_w = 4;
	localparam int cfg_shift_addr = 9;

endpackage

// File: hw/img_filter_top.sv
`timescale 1ns/1ns

module img_filter_top (
	input  logic clk,
	input  logic reset,
	input  logic i_cfg_req,
	input  logic [img_filter_pkg::cfg_addr_w-1:0] i_cfg_addr,
	input  logic signed [img_filter_pkg::coef_w-1:0] i_cfg_wdata,
	input  logic i_pixel_valid,
	input  logic [img_filter_pkg::pixel_w-1:0] i_pixel,
	output logic o_cfg_ack,
	output logic o_valid,
	output logic o_frame_done,
	output logic [img_filter_pkg::pixel_w-1:0] o_data
);
	import img_filter_pkg::*;

	// Kernel settings, static while a frame streams
	logic [num_coefs*coef_w-1:0] coefs;
	logic [shift_w-1:0] shift;

	kernel_config u_kernel_config (
		.clk         (clk),
		.reset       (reset),
		.i_cfg_req   (i_cfg_req),
		.i_cfg_addr  (i_cfg_addr),
		.i_cfg_wdata (i_cfg_wdata),
		.o_cfg_ack   (o_cfg_ack),
		.o_coefs     (coefs),
		.o_shift     (shift)
	);

	filter u_filter (
		.clk           (clk),
		.reset         (reset),
		.i_pixel_valid (i_pixel_valid),
		.i_pixel       (i_pixel),
		.i_coefs       (coefs),
		.i_shift       (shift),
		.o_valid       (o_valid),
		.o_frame_done  (o_frame_done),
		.o_data        (o_data)
	);

endmodule

// File: hw/kernel_config.sv
`timescale 1ns/1ns

module kernel_config (
	input  logic clk,
	input  logic reset,
	input  logic i_cfg_req,
	input  logic [img_filter_pkg::cfg_addr_w-1:0] i_cfg_addr,
	input  logic signed [img_filter_pkg::coef_w-1:0] i_cfg_wdata,
	output logic o_cfg_ack,
	output logic [img_filter_pkg::num_coefs*img_filter_pkg::coef_w-1:0] o_coefs,
	output logic [img_filter_pkg::shift_w-1:0] o_shift
);
	import img_filter_pkg::*;

	// Coefficient registers, row-major from top-left
	logic signed [coef_w-1:0] coef_q [num_coefs];

	// Four-phase slave side
	// Write happens once, on the first edge with req high and ack low
	always_ff @(posedge clk) begin
		if (reset) begin
			o_cfg_ack <= 1'b0;
			o_shift <= '0;
			for (int k = 0; k < num_coefs; k++) begin
				coef_q[k] <= '0;
			end
		end else if (i_cfg_req && !o_cfg_ack) begin
			o_cfg_ack <= 1'b1;
			if (i_cfg_addr < cfg_shift_addr) begin
				coef_q[i_cfg_addr] <= i_cfg_wdata;
			end else if (i_cfg_addr == cfg_shift_addr) begin
				// Only the low bits carry the shift
				o_shift <= i_cfg_wdata[shift_w-1:0];
			end
			// Higher addresses still get their ack
		end else if (!i_cfg_req && o_cfg_ack) begin
			// Master released req, close the handshake
			o_cfg_ack <= 1'b0;
		end
	end

	// Pack for the filter
	always_comb begin
		for (int k = 0; k < num_coefs; k++) begin
			o_coefs[k*coef_w +: coef_w] = coef_q[k];
		end
	end

	// Master must hold req until the ack arrives
	req_held_for_ack: assert property (
		@(posedge clk) disable iff (reset)
		(i_cfg_req && !o_cfg_ack) |=> i_cfg_req
	) else $error("cfg req dropped before ack");

endmodule

// File: hw/kernel_convolver.sv
`timescale 1ns/1ns

module kernel_convolver (
	input  logic clk,
	input  logic reset,
	input  logic i_advance,
	input  logic i_valid,
	input  logic i_done,
	input  logic [img_filter_pkg::kernel_size*img_filter_pkg::pixel_w-1:0] i_taps,
	input  logic [img_filter_pkg::num_coefs*img_filter_pkg::coef_w-1:0] i_coefs,
	input  logic [img_filter_pkg::shift_w-1:0] i_shift,
	output logic o_valid,
	output logic o_done,
	output logic signed [img_filter_pkg::acc_w-1:0] o_data
);
	import img_filter_pkg::*;

	// Window, [row][col] with row 0 on top and col 0 the oldest column
	logic [pixel_w-1:0] window [kernel_size][kernel_size];
	logic win_valid;
	logic win_done;

	// Stage one
	logic signed [prod_w-1:0] prod [num_coefs];
	logic prod_valid;
	logic prod_done;

	// Sum of the registered products
	logic signed [acc_w-1:0] acc_sum;

	// The window moves on every accepted pixel, also on border columns,
	// so the two older columns are right when a result is due
	always_ff @(posedge clk) begin
		if (i_advance) begin
			for (int r = 0; r < kernel_size; r++) begin
				for (int c = 0; c < kernel_size - 1; c++) begin
					window[r][c] <= window[r][c + 1];
				end
				// Top row sits in the upper slice of the tap bus
				window[r][kernel_size - 1] <=
					i_taps[(kernel_size - 1 - r)*pixel_w +: pixel_w];
			end
		end
	end

	// Products, pixel widened with a zero sign bit
	always_ff @(posedge clk) begin
		for (int k = 0; k < num_coefs; k++) begin
			prod[k] <= $signed({1'b0, window[k / kernel_size][k % kernel_size]})
				* $signed(i_coefs[k*coef_w +: coef_w]);
		end
	end

	always_comb begin
		acc_sum = '0;
		for (int k = 0; k < num_coefs; k++) begin
			acc_sum = acc_sum + acc_w'(prod[k]);
		end
	end

	// Stage two, arithmetic shift keeps the sign for the clamp
	always_ff @(posedge clk) begin
		o_data <= acc_sum >>> i_shift;
	end

	// Flags run beside the data and never stall
	always_ff @(posedge clk) begin
		if (reset) begin
			win_valid <= 1'b0;
			win_done <= 1'b0;
			prod_valid <= 1'b0;
			prod_done <= 1'b0;
			o_valid <= 1'b0;
			o_done <= 1'b0;
		end else begin
			win_valid <= i_valid;
			win_done <= i_done;
			prod_valid <= win_valid;
			prod_done <= win_done;
			o_valid <= prod_valid;
			o_done <= prod_done;
		end
	end

	// Filter spaces done one cycle behind the last window
	done_apart_from_valid: assert property (
		@(posedge clk) disable iff (reset)
		!(o_valid && o_done)
	) else $error("convolver done overlaps a valid result");

endmodule

// File: project.f
hw/img_filter_pkg.sv
hw/kernel_config.sv
hw/kernel_convolver.sv
hw/filter.sv
hw/img_filter_top.sv
verification/tb_img_filter.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then judge the run from its log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_img_filter \
	-Mdir obj_dir -f project.f > build.log 2>&1 \
	|| { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/Vtb_img_filter > sim.log 2>&1 || true
cat sim.log
grep -q "^Simulation completed successfully$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: verification/filter_vectors.txt
// Each frame opens with nine hex coefficients in row-major order and the shift on one line
// followed by 6 padded input rows of 8 pixels and 4 expected output rows of 6 pixels
00 00 00 00 01 00 00 00 00 00
00 00 00 00 00 00 00 00
00 11 22 33 44 55 66 00
00 77 88 99 aa bb cc 00
00 dd ee ff 01 02 03 00
00 10 20 30 40 50 60 00
00 00 00 00 00 00 00 00
11 22 33 44 55 66
77 88 99 aa bb cc
dd ee ff 01 02 03
10 20 30 40 50 60
ff ff ff ff 09 ff ff ff ff 00
00 00 00 00 00 00 00 00
00 00 00 c8 c8 00 00 00
00 00 00 c8 c8 00 00 00
00 32 32 32 32 32 32 00
00 1e 1e 1e 1e 1e 1e 00
00 00 00 00 00 00 00 00
00 00 ff ff 00 00
00 00 ff ff 00 00
ff 3c 00 00 3c ff
8c 3c 3c 3c 3c 8c
01 01 01 01 01 01 01 01 01 03
00 00 00 00 00 00 00 00
00 00 00 c8 c8 00 00 00
00 00 00 c8 c8 00 00 00
00 32 32 32 32 32 32 00
00 1e 1e 1e 1e 1e 1e 00
00 00 00 00 00 00 00 00
00 32 64 64 32 00
0c 44 76 76 44 0c
14 37 50 50 37 14
14 1e 1e 1e 1e 14

// File: verification/tb_img_filter.sv
`timescale 1ns/1ns

module tb_img_filter;
	import img_filter_pkg::*;

	localparam int num_frames = 3;
	localparam int num_pix = img_width * img_height;
	localparam int pad_rows = img_height + 2;
	localparam int timeout_cycles = 300;

	logic clk;
	logic reset;
	logic i_cfg_req;
	logic [cfg_addr_w-1:0] i_cfg_addr;
	logic signed [coef_w-1:0] i_cfg_wdata;
	logic i_pixel_valid;
	logic [pixel_w-1:0] i_pixel;
	logic o_cfg_ack;
	logic o_valid;
	logic o_frame_done;
	logic [pixel_w-1:0] o_data;

	// Current frame record, nine coefficients then the shift
	logic [coef_w-1:0] cfg_vals [num_coefs + 1];
	logic [pixel_w-1:0] pad_pix [pad_rows][row_depth];
	logic [pixel_w-1:0] exp_pix [num_pix];

	int fd;
	int seed = 46;
	int res_cnt = 0;
	int done_cnt = 0;
	logic [8*128-1:0] line_buf;

	// o_valid seen on the previous edge
	logic valid_q = 1'b0;

	img_filter_top DUT (
		.clk           (clk),
		.reset         (reset),
		.i_cfg_req     (i_cfg_req),
		.i_cfg_addr    (i_cfg_addr),
		.i_cfg_wdata   (i_cfg_wdata),
		.i_pixel_valid (i_pixel_valid),
		.i_pixel       (i_pixel),
		.o_cfg_ack     (o_cfg_ack),
		.o_valid       (o_valid),
		.o_frame_done  (o_frame_done),
		.o_data        (o_data)
	);

	// 20 ns period
	always #10 clk = ~clk;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	// Step to 1 ns past the next rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic check_pixel(input logic [pixel_w-1:0] got, input logic [pixel_w-1:0] exp,
			input int idx);
		if (got !== exp) begin
			abort_run($sformatf("FAIL %0t: frame %0d pixel row %0d col %0d got %0d expected %0d",
				$time, done_cnt + 1, idx / img_width, idx % img_width, got, exp));
		end
	endtask

	task automatic check_done(input int count);
		if (count != num_pix) begin
			abort_run($sformatf("FAIL %0t: frame done after %0d results, expected %0d",
				$time, count, num_pix));
		end
	endtask

	task automatic read_hex(output logic [pixel_w-1:0] val);
		int code;
		code = $fscanf(fd, "%h", val);
		if (code != 1) begin
			abort_run("The vectors file ended early or holds a value that is not hex");
		end
	endtask

	// Kernel, padded input rows, then expected rows
	task automatic load_frame();
		for (int k = 0; k <= num_coefs; k++) read_hex(cfg_vals[k]);
		for (int r = 0; r < pad_rows; r++) begin
			for (int c = 0; c < row_depth; c++) read_hex(pad_pix[r][c]);
		end
		for (int i = 0; i < num_pix; i++) read_hex(exp_pix[i]);
	endtask

	// Four-phase write, req held through the edge that registers ack
	task automatic cfg_write(input logic [cfg_addr_w-1:0] addr, input logic [coef_w-1:0] data);
		int cycles;
		i_cfg_addr = addr;
		i_cfg_wdata = data;
		i_cfg_req = 1'b1;
		cycles = 0;
		while (o_cfg_ack !== 1'b1) begin
			next_cycle();
			cycles++;
			if (cycles > timeout_cycles) abort_run("Config ack never rose after req was raised");
		end
		next_cycle();
		i_cfg_req = 1'b0;
		cycles = 0;
		while (o_cfg_ack !== 1'b0) begin
			next_cycle();
			cycles++;
			if (cycles > timeout_cycles) abort_run("Config ack never fell after req was dropped");
		end
	endtask

	// Each pixel waits 0..2 stall cycles with valid low
	task automatic stream_frame();
		int nstall;
		for (int r = 0; r < pad_rows; r++) begin
			for (int c = 0; c < row_depth; c++) begin
				nstall = {$random(seed)} % 6;
				if (nstall > 2) nstall = 0;
				i_pixel = pad_pix[r][c];
				i_pixel_valid = 1'b0;
				repeat (nstall) next_cycle();
				i_pixel_valid = 1'b1;
				next_cycle();
			end
		end
		i_pixel_valid = 1'b0;
	endtask

	task automatic wait_frame_done(input int frame);
		int cycles;
		cycles = 0;
		while (done_cnt <= frame) begin
			next_cycle();
			cycles++;
			if (cycles > timeout_cycles) abort_run("Frame done never arrived after the last pixel");
		end
	endtask

	// Collector, results in raster order
	always @(posedge clk) begin
		if (!reset) begin
			if (o_valid) begin
				if (res_cnt >= num_pix) abort_run("The DUT gave more results than the frame has");
				check_pixel(o_data, exp_pix[res_cnt], res_cnt);
				res_cnt++;
			end
			// A done held two cycles fails here on a zero count
			if (o_frame_done) begin
				check_done(res_cnt);
				if (o_valid || !valid_q) begin
					abort_run("Frame done was not in the cycle after the last result");
				end
				res_cnt = 0;
				done_cnt++;
			end
		end
		valid_q = o_valid;
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		i_cfg_req = 1'b0;
		i_cfg_addr = '0;
		i_cfg_wdata = '0;
		i_pixel_valid = 1'b0;
		i_pixel = '0;
		fd = $fopen("verification/filter_vectors.txt", "r");
		if (fd == 0) abort_run("Cannot open verification/filter_vectors.txt");
		// Skip the two column description lines
		void'($fgets(line_buf, fd));
		void'($fgets(line_buf, fd));
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;
		// Frames follow each other without a reset
		for (int f = 0; f < num_frames; f++) begin
			load_frame();
			for (int k = 0; k <= num_coefs; k++) cfg_write(cfg_addr_w'(k), cfg_vals[k]);
			stream_frame();
			wait_frame_done(f);
		end
		$fclose(fd);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule
